// File: game_link_pkg.sv
// game link package: remote player record, decoder states and frame constants
package game_link_pkg;

    // decoded state of one remote player, as published after a full frame
    typedef struct packed {
        logic [11:0] x;                 // horizontal position
        logic [11:0] y;                 // vertical position
        logic [3:0]  hp;
        logic [3:0]  aggro;
        logic        flip_h;            // sprite faces left
        logic [1:0]  player_class;
        logic [6:0]  boss_hp;
        logic        game_start;        // taken from the last byte of the frame
    } remote_state_t;

    // position inside an 11-byte frame, named after the byte expected next
    typedef enum logic [3:0] {
        HUNT,                           // waiting for the header byte
        X_LO,
        X_HI,
        Y_LO,
        Y_HI,
        HP,
        AGGRO,
        FLIP,
        CLASS,
        BOSS_HP,
        START                           // final byte, publishes the record
    } frame_state_t;

    // ascii 'D' opens every frame
    localparam logic [7:0] FRAME_HEADER = 8'h44;

    // header plus ten payload bytes
    localparam int FRAME_BYTES = 11;

endpackage

// File: baud_tick_gen.sv
// oversample tick generator: one-cycle pulse every TICK_DIV clocks for all lanes
`timescale 1ns/1ps

module baud_tick_gen #(
    parameter int TICK_DIV = 2
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CNT_W-1:0] div_cnt;

    // tick is registered, so the first pulse shows TICK_DIV cycles after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            if (div_cnt == CNT_W'(TICK_DIV - 1)) begin
                div_cnt <= '0;
                tick    <= 1'b1;                // wrap pulse
            end else begin
                div_cnt <= div_cnt + 1'b1;
                tick    <= 1'b0;
            end
        end
    end

endmodule

// File: uart_byte_rx.sv
// 8N1 serial byte receiver, 16x oversampled on the shared tick, drops bad stop bits
`timescale 1ns/1ps

module uart_byte_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic       rxd,
    output logic [7:0] rx_byte,
    output logic       rx_strobe
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t  state;
    logic [1:0] sync;                           // 2-flop synchronizer
    logic       rxd_s;
    logic       armed;                          // line seen high since last byte
    logic [3:0] tick_cnt;
    logic [2:0] bit_cnt;
    logic [7:0] data_sr;

    assign rxd_s   = sync[1];
    assign rx_byte = data_sr;                   // stable until the next data bit

    always_ff @(posedge clk) begin
        if (rst) begin
            sync <= 2'b11;                      // idle line level
        end else begin
            sync <= {sync[0], rxd};
        end
    end

    // data shift register, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && tick && tick_cnt == 4'd15) begin
            data_sr <= {rxd_s, data_sr[7:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= RX_IDLE;
            armed     <= 1'b0;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            if (tick) begin
                case (state)
                    RX_IDLE: begin
                        if (rxd_s) begin
                            armed <= 1'b1;
                        end else if (armed) begin
                            state    <= RX_START;   // this tick is tick 1 of start
                            tick_cnt <= 4'd1;
                        end
                    end
                    RX_START: begin
                        if (tick_cnt == 4'd7) begin
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            if (!rxd_s) begin
                                state <= RX_DATA;   // start confirmed mid-bit
                            end else begin
                                state <= RX_IDLE;   // glitch, false start
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                    RX_DATA: begin
                        tick_cnt <= tick_cnt + 1'b1;    // wraps to 0 after the sample
                        if (tick_cnt == 4'd15) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) begin
                                state <= RX_STOP;
                            end
                        end
                    end
                    RX_STOP: begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == 4'd15) begin
                            rx_strobe <= rxd_s;     // framing error drops the byte
                            armed     <= 1'b0;      // wait for high after a low stop
                            state     <= RX_IDLE;
                        end
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

endmodule

// File: game_frame_decoder.sv
// frame decoder: walks the 11-byte frame and publishes one remote player record
`timescale 1ns/1ps

module game_frame_decoder
    import game_link_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic [7:0]    rx_byte,
    input  logic          rx_strobe,
    output remote_state_t state_out,
    output logic          frame_done
);

    frame_state_t  state;
    remote_state_t hold;                        // fields of the frame in flight
    remote_state_t publish;

    // the final byte carries game start, so it bypasses the holding record
    always_comb begin
        publish            = hold;
        publish.game_start = rx_byte[0];
    end

    // field capture, unused bits of each byte are dropped
    always_ff @(posedge clk) begin
        if (rx_strobe) begin
            case (state)
                HUNT: begin
                    if (rx_byte == FRAME_HEADER) begin
                        hold <= '0;             // fresh frame
                    end
                end
                X_LO:    hold.x[7:0]       <= rx_byte;
                X_HI:    hold.x[11:8]      <= rx_byte[3:0];
                Y_LO:    hold.y[7:0]       <= rx_byte;
                Y_HI:    hold.y[11:8]      <= rx_byte[3:0];
                HP:      hold.hp           <= rx_byte[3:0];
                AGGRO:   hold.aggro        <= rx_byte[3:0];
                FLIP:    hold.flip_h       <= rx_byte[0];
                CLASS:   hold.player_class <= rx_byte[1:0];
                BOSS_HP: hold.boss_hp      <= rx_byte[6:0];
                default: ;
            endcase
        end
    end

    // position in frame, record publish and done pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= HUNT;
            state_out  <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (rx_strobe) begin
                case (state)
                    HUNT: begin
                        if (rx_byte == FRAME_HEADER) begin
                            state <= X_LO;
                        end
                    end
                    X_LO:    state <= X_HI;
                    X_HI:    state <= Y_LO;
                    Y_LO:    state <= Y_HI;
                    Y_HI:    state <= HP;
                    HP:      state <= AGGRO;
                    AGGRO:   state <= FLIP;
                    FLIP:    state <= CLASS;
                    CLASS:   state <= BOSS_HP;
                    BOSS_HP: state <= START;
                    START: begin
                        state_out  <= publish;  // whole record at once
                        frame_done <= 1'b1;
                        state      <= HUNT;
                    end
                    default: state <= HUNT;
                endcase
            end
        end
    end

endmodule

// File: frame_collector.sv
// record collector: one pending slot per lane, round-robin drain of tagged records
`timescale 1ns/1ps

module frame_collector
    import game_link_pkg::*;
#(
    parameter int NUM_LINKS = 4,
    localparam int LANE_W = (NUM_LINKS > 1) ? $clog2(NUM_LINKS) : 1
) (
    input  logic                          clk,
    input  logic                          rst,
    input  remote_state_t [NUM_LINKS-1:0] lane_state,
    input  logic          [NUM_LINKS-1:0] lane_done,
    output logic                          out_valid,
    output logic          [LANE_W-1:0]    out_lane,
    output remote_state_t                 out_state
);

    logic          [NUM_LINKS-1:0] pending;
    remote_state_t [NUM_LINKS-1:0] lane_rec;
    logic          [NUM_LINKS-1:0] req;
    logic          [LANE_W-1:0]    last_grant;
    logic          [LANE_W-1:0]    grant_idx;
    logic                          grant_valid;
    remote_state_t                 grant_rec;

    // a record arriving this cycle competes right away
    assign req = pending | lane_done;

    // rotating priority, first requester after the last granted lane
    always_comb begin
        int idx;
        grant_valid = 1'b0;
        grant_idx   = last_grant;
        for (int k = NUM_LINKS; k >= 1; k--) begin
            idx = (int'(last_grant) + k) % NUM_LINKS;
            if (req[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = LANE_W'(idx);     // smallest offset wins
            end
        end
        grant_rec = lane_done[grant_idx] ? lane_state[grant_idx] : lane_rec[grant_idx];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending    <= '0;
            lane_rec   <= '0;
            last_grant <= LANE_W'(NUM_LINKS - 1);   // lane 0 has first priority
            out_valid  <= 1'b0;
            out_lane   <= '0;
            out_state  <= '0;
        end else begin
            out_valid <= grant_valid;
            for (int i = 0; i < NUM_LINKS; i++) begin
                if (lane_done[i]) begin
                    lane_rec[i] <= lane_state[i];
                end
                pending[i] <= req[i] && !(grant_valid && grant_idx == LANE_W'(i));
            end
            if (grant_valid) begin
                last_grant <= grant_idx;
                out_lane   <= grant_idx;
                out_state  <= grant_rec;
            end
        end
    end

endmodule

// File: game_link_hub.sv
// game link receive hub: shared tick, one serial lane per console, record collector
`timescale 1ns/1ps

module game_link_hub
    import game_link_pkg::*;
#(
    parameter int NUM_LINKS = 4,
    parameter int TICK_DIV  = 2,
    localparam int LANE_W = (NUM_LINKS > 1) ? $clog2(NUM_LINKS) : 1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [NUM_LINKS-1:0] rxd,
    output logic                 out_valid,
    output logic [LANE_W-1:0]    out_lane,
    output remote_state_t        out_state
);

    logic                          tick;
    logic          [7:0]           lane_byte [NUM_LINKS];
    logic          [NUM_LINKS-1:0] lane_strobe;
    remote_state_t [NUM_LINKS-1:0] lane_state;
    logic          [NUM_LINKS-1:0] lane_done;

    baud_tick_gen #(
        .TICK_DIV (TICK_DIV)
    ) baud_tick_gen_inst (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    for (genvar i = 0; i < NUM_LINKS; i++) begin : g_lane
        uart_byte_rx uart_byte_rx_inst (
            .clk       (clk),
            .rst       (rst),
            .tick      (tick),
            .rxd       (rxd[i]),
            .rx_byte   (lane_byte[i]),
            .rx_strobe (lane_strobe[i])
        );

        game_frame_decoder game_frame_decoder_inst (
            .clk        (clk),
            .rst        (rst),
            .rx_byte    (lane_byte[i]),
            .rx_strobe  (lane_strobe[i]),
            .state_out  (lane_state[i]),
            .frame_done (lane_done[i])
        );
    end

    frame_collector #(
        .NUM_LINKS (NUM_LINKS)
    ) frame_collector_inst (
        .clk        (clk),
        .rst        (rst),
        .lane_state (lane_state),
        .lane_done  (lane_done),
        .out_valid  (out_valid),
        .out_lane   (out_lane),
        .out_state  (out_state)
    );

endmodule

// File: tb_game_link_hub_sva.sv
// bound checks on the record collector arbitration and the frame decoder states
`timescale 1ns/1ps

module tb_game_link_hub_sva
    import game_link_pkg::*;
#(
    parameter int NUM_LINKS = 4,
    localparam int LANE_W = (NUM_LINKS > 1) ? $clog2(NUM_LINKS) : 1
) (
    input logic                 clk,
    input logic                 rst,
    input logic                 out_valid,
    input logic [LANE_W-1:0]    out_lane,
    input logic [NUM_LINKS-1:0] lane_done,
    input logic [NUM_LINKS-1:0] pending,
    input frame_state_t         dec_state
);

    int fail_cnt = 0;                           // failed assertions in this instance

    // a lane is granted at most once per record
    assert property (@(posedge clk) disable iff (rst)
        out_valid ##1 out_valid |-> out_lane != $past(out_lane))
    else begin
        $error("same lane granted in two consecutive cycles");
        fail_cnt++;
    end

    // a new record must never overwrite one still waiting
    for (genvar i = 0; i < NUM_LINKS; i++) begin : g_slot
        assert property (@(posedge clk) disable iff (rst)
            lane_done[i] |-> !pending[i])
        else begin
            $error("frame done on lane %0d while its record is pending", i);
            fail_cnt++;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        dec_state <= START)
    else begin
        $error("decoder left the legal frame states");
        fail_cnt++;
    end

endmodule

// collector instance with the decoder port tied to a legal state
bind frame_collector tb_game_link_hub_sva #(
    .NUM_LINKS (NUM_LINKS)
) collector_sva_inst (
    .clk       (clk),
    .rst       (rst),
    .out_valid (out_valid),
    .out_lane  (out_lane),
    .lane_done (lane_done),
    .pending   (pending),
    .dec_state (game_link_pkg::HUNT)
);

// decoder instance with the collector ports tied idle
bind game_frame_decoder tb_game_link_hub_sva #(
    .NUM_LINKS (1)
) decoder_sva_inst (
    .clk       (clk),
    .rst       (rst),
    .out_valid (1'b0),
    .out_lane  (1'b0),
    .lane_done (1'b0),
    .pending   (1'b0),
    .dec_state (state)
);

// File: tb_game_link_hub.sv
// testbench for the game link hub that checks random serial frames against a record model
`timescale 1ns/1ps

module tb_game_link_hub
    import game_link_pkg::*;
;

    localparam int NUM_LINKS      = 4;
    localparam int TICK_DIV       = 2;
    localparam int LANE_W         = 2;
    localparam int BIT_CYCLES     = 16 * TICK_DIV;     // 32 clocks per serial bit
    localparam int NUM_TESTS      = 5;
    localparam int TOTAL_FRAMES   = 1 + 1 + 1 + 4 + 40;
    localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * FRAME_BYTES * 320 + 10000;

    logic                 clk;
    logic                 rst;
    logic [NUM_LINKS-1:0] rxd;
    logic                 out_valid;
    logic [LANE_W-1:0]    out_lane;
    remote_state_t        out_state;

    logic [31:0]          lfsr_state;
    int                   exp_lane[$];                  // lane of each frame in flight
    remote_state_t        exp_rec[$];
    int                   err_cnt;
    int                   pass_cnt;
    int                   cycle_cnt;

    game_link_hub #(
        .NUM_LINKS (NUM_LINKS),
        .TICK_DIV  (TICK_DIV)
    ) game_link_hub_inst (
        .clk       (clk),
        .rst       (rst),
        .rxd       (rxd),
        .out_valid (out_valid),
        .out_lane  (out_lane),
        .out_state (out_state)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    // header then ten random payload bytes with byte k at bits 8k+7..8k
    function automatic logic [FRAME_BYTES*8-1:0] make_frame();
        logic [FRAME_BYTES*8-1:0] f;
        f[7:0] = FRAME_HEADER;
        for (int k = 1; k < FRAME_BYTES; k++) begin
            f[8*k +: 8] = 8'(rand_bits(8));
        end
        return f;
    endfunction

    // reference record built from the frame layout
    function automatic remote_state_t expected_record(input logic [FRAME_BYTES*8-1:0] f);
        remote_state_t rec;
        rec.x            = {f[8*2 +: 4], f[8*1 +: 8]};
        rec.y            = {f[8*4 +: 4], f[8*3 +: 8]};
        rec.hp           = f[8*5 +: 4];
        rec.aggro        = f[8*6 +: 4];
        rec.flip_h       = f[8*7];
        rec.player_class = f[8*8 +: 2];
        rec.boss_hp      = f[8*9 +: 7];
        rec.game_start   = f[8*10];              // start bit of this same frame
        return rec;
    endfunction

    function automatic int find_expect(input int lane);
        for (int k = 0; k < exp_lane.size(); k++) begin
            if (exp_lane[k] == lane) begin
                return k;
            end
        end
        return -1;
    endfunction

    // checker errors plus failed assertions in the bound checkers
    function automatic int error_total();
        return err_cnt
             + game_link_hub_inst.frame_collector_inst.collector_sva_inst.fail_cnt
             + game_link_hub_inst.g_lane[0].game_frame_decoder_inst.decoder_sva_inst.fail_cnt
             + game_link_hub_inst.g_lane[1].game_frame_decoder_inst.decoder_sva_inst.fail_cnt
             + game_link_hub_inst.g_lane[2].game_frame_decoder_inst.decoder_sva_inst.fail_cnt
             + game_link_hub_inst.g_lane[3].game_frame_decoder_inst.decoder_sva_inst.fail_cnt;
    endfunction

    task automatic expect_frame(input int lane, input logic [FRAME_BYTES*8-1:0] f);
        exp_lane.push_back(lane);
        exp_rec.push_back(expected_record(f));
    endtask

    // one 8N1 byte on a lane where a low stop_val gives a framing error
    task automatic send_byte(input int lane, input logic [7:0] b, input logic stop_val);
        logic [9:0] bits;
        bits = {stop_val, b, 1'b0};              // start, data LSB first, stop
        for (int k = 0; k < 10; k++) begin
            @(posedge clk);
            rxd[lane] <= bits[k];
            repeat (BIT_CYCLES - 1) @(posedge clk);
        end
        if (!stop_val) begin
            @(posedge clk);
            rxd[lane] <= 1'b1;                   // idle so the receiver re-arms
            repeat (BIT_CYCLES - 1) @(posedge clk);
        end
    endtask

    task automatic send_frame(input int lane, input logic [FRAME_BYTES*8-1:0] f);
        for (int k = 0; k < FRAME_BYTES; k++) begin
            send_byte(lane, f[8*k +: 8], 1'b1);
        end
    endtask

    // wait until every expected record has come out
    task automatic wait_drain();
        while (exp_lane.size() != 0) begin
            @(posedge clk);
        end
        repeat (40) @(posedge clk);              // quiet gap shows stray records
    endtask

    task automatic report_test(input string name, input int err_before);
        if (error_total() == err_before) begin
            pass_cnt++;
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail, %0d errors", name, error_total() - err_before);
        end
    endtask

    // records are sampled away from the rising edge
    always @(negedge clk) begin
        int idx;
        if (!rst && out_valid) begin
            idx = find_expect(int'(out_lane));
            if (idx < 0) begin
                err_cnt++;
                $display("at %0t a record came out on lane %0d but no frame was pending there",
                         $time, out_lane);
            end else begin
                if (out_state !== exp_rec[idx]) begin
                    err_cnt++;
                    $display("FAILED at %0t: lane %0d record %h, expected %h",
                             $time, out_lane, out_state, exp_rec[idx]);
                end
                exp_lane.delete(idx);
                exp_rec.delete(idx);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles with %0d records still missing",
                     cycle_cnt, exp_lane.size());
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        logic [FRAME_BYTES*8-1:0] frames [NUM_LINKS];
        logic [7:0]               junk;
        int                       err_before;
        lfsr_state = 32'h2fcf44a7;
        err_cnt    = 0;
        pass_cnt   = 0;
        cycle_cnt  = 0;
        rst        = 1'b1;
        rxd        = '1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (40) @(posedge clk);              // lines idle high to arm receivers

        err_before = error_total();
        frames[0] = make_frame();
        expect_frame(0, frames[0]);
        send_frame(0, frames[0]);
        wait_drain();
        report_test("single frame", err_before);

        err_before = error_total();
        for (int k = 0; k < 3; k++) begin
            junk = 8'(rand_bits(8));
            if (junk == FRAME_HEADER) begin
                junk = junk ^ 8'h01;
            end
            send_byte(2, junk, 1'b1);
        end
        frames[2] = make_frame();
        expect_frame(2, frames[2]);
        send_frame(2, frames[2]);
        wait_drain();
        report_test("junk before header", err_before);

        err_before = error_total();
        send_byte(1, FRAME_HEADER, 1'b0);        // must be dropped
        frames[1] = make_frame();
        expect_frame(1, frames[1]);
        send_frame(1, frames[1]);
        wait_drain();
        report_test("bad stop bit", err_before);

        err_before = error_total();
        for (int l = 0; l < NUM_LINKS; l++) begin
            frames[l] = make_frame();
            expect_frame(l, frames[l]);
        end
        fork
            send_frame(0, frames[0]);
            send_frame(1, frames[1]);
            send_frame(2, frames[2]);
            send_frame(3, frames[3]);
        join
        wait_drain();
        report_test("simultaneous frames", err_before);

        err_before = error_total();
        for (int l = 0; l < NUM_LINKS; l++) begin
            for (int n = 0; n < 10; n++) begin
                frames[l] = make_frame();
                expect_frame(l, frames[l]);
                send_frame(l, frames[l]);
            end
        end
        wait_drain();
        report_test("back-to-back frames", err_before);

        $display("%0d of %0d tests passed, %0d errors", pass_cnt, NUM_TESTS, error_total());
        if (error_total() == 0 && pass_cnt == NUM_TESTS) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
game_link_pkg.sv
baud_tick_gen.sv
uart_byte_rx.sv
game_frame_decoder.sv
frame_collector.sv
game_link_hub.sv
tb_game_link_hub_sva.sv
tb_game_link_hub.sv

// File: Bender.yml
package:
  name: game_link_hub

sources:
  - game_link_pkg.sv
  - baud_tick_gen.sv
  - uart_byte_rx.sv
  - game_frame_decoder.sv
  - frame_collector.sv
  - game_link_hub.sv
  - target: test
    files:
      - tb_game_link_hub_sva.sv
      - tb_game_link_hub.sv
